// ==== include/mips_defs.svh ====
/* Width, depth, reset and opcode macros for the load-only MIPS core */

`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath widths
`define MIPS_DATA_W     32          // Data and instruction word
`define MIPS_ADDR_W     32          // addr pin and program counter

// Storage geometry
`define MIPS_MEM_DEPTH  32          // Words per memory
`define MIPS_IDX_W      5           // Low address bits picking a word

// Program counter after reset
`define MIPS_RESET_PC   32'd0

// Supported opcodes, bits 31:26 of the instruction
// I format: opcode | rs | rt | imm
`define MIPS_OP_LBU     6'b100100   // Load byte unsigned
`define MIPS_OP_LHU     6'b100101   // Load halfword unsigned
`define MIPS_OP_LUI     6'b001111   // Load upper immediate
`define MIPS_OP_LW      6'b100011   // Load word

// Everything else decodes to a no-op

`endif

// ==== rtl/mips_pkg.sv ====
/* Shared types of the load-only core: words, instruction fields,
   indices, debug target select and load control */

`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

    // Plain 32-bit data word
    typedef logic [`MIPS_DATA_W-1:0] data_t;

    // Register file index, rs/rt field width
    typedef logic [4:0] reg_idx_t;

    // Word select inside a memory
    typedef logic [`MIPS_IDX_W-1:0] mem_idx_t;

    // I format instruction, MSB first
    typedef struct packed {
        logic [5:0]  opcode;    // Bits 31:26
        reg_idx_t    rs;        // Base register
        reg_idx_t    rt;        // Destination register
        logic [15:0] imm;       // Offset or upper immediate
    } instr_t;

    // Back door target, values fixed by the debug_func pin
    typedef enum logic [1:0] {
        dbg_none = 2'd0,
        dbg_im   = 2'd1,        // Instruction memory
        dbg_dm   = 2'd2,        // Data memory
        dbg_mr   = 2'd3         // Register file
    } debug_sel_t;

    // How the load result is formed
    typedef enum logic [1:0] {
        ld_byte,                // Low byte, zero-extended
        ld_half,                // Low halfword, zero-extended
        ld_word,                // Whole word
        ld_upper                // imm in the upper half
    } load_kind_t;

    // Decoder output, 3 bits
    typedef struct packed {
        logic       reg_we;     // Write rt this cycle
        load_kind_t kind;
    } load_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/ram_port_if.sv ====
/* One memory port: word index, write data, write enable, read data */

`timescale 1ns/1ps
`default_nettype none

interface ram_port_if #(
    parameter type word_t = mips_pkg::data_t
);
    import mips_pkg::*;

    mem_idx_t idx;      // Word select
    word_t    wdata;    // Written at the rising edge
    logic     we;       // Single-cycle level
    word_t    rdata;    // Combinational read at idx

    // Side that owns the address and write
    modport host (output idx, output wdata, output we, input rdata);

    // Memory side
    modport ram (input idx, input wdata, input we, output rdata);

endinterface

`default_nettype wire

// ==== rtl/sync_ram.sv ====
/* Word memory with combinational read and clocked write, cleared on reset,
   payload type set by parameter */

`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module sync_ram #(
    parameter type word_t = mips_pkg::data_t
) (
    input  wire logic  mem_debug_clk_gate,
    input  wire logic  HW_RSTn,
    ram_port_if.ram    port
);

    word_t mem [`MIPS_MEM_DEPTH];   // Storage array

    // Write port
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            // Whole array reads zero after reset
            for (int i = 0; i < `MIPS_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (port.we) begin
            mem[port.idx] <= port.wdata;   // Full word only
        end
    end

    // Read is asynchronous, same-cycle for fetch and debug
    assign port.rdata = mem[port.idx];

    // Enable from the core mux must stay clean once out of reset
    a_we_known: assert property (
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        !$isunknown(port.we)
    ) else $error("sync_ram: write enable unknown");

    // Index must be defined whenever a write happens
    a_idx_known: assert property (
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        port.we |-> !$isunknown(port.idx)
    ) else $error("sync_ram: write to unknown index");

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
/* 32-entry register file, two read ports, one write port, r0 tied to zero */

`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic               mem_debug_clk_gate,
    input  wire logic               HW_RSTn,
    input  wire mips_pkg::reg_idx_t ra_idx,     // rs in execution
    input  wire mips_pkg::reg_idx_t rb_idx,     // rt, or debug index
    input  wire mips_pkg::reg_idx_t w_idx,
    input  wire mips_pkg::data_t    w_data,
    input  wire logic               we,
    output mips_pkg::data_t         ra_data,
    output mips_pkg::data_t         rb_data
);
    import mips_pkg::*;

    localparam int NUM_REGS = 1 << $bits(reg_idx_t);   // 32

    data_t regs [NUM_REGS];

    // Single write port, r0 never stored
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (w_idx != '0)) begin
            regs[w_idx] <= w_data;
        end
    end

    // Reads are combinational
    // r0 forced to zero on both ports
    always_comb begin
        ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
        rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];
    end

    // Load result or din must be settled when written
    a_wdata_known: assert property (
        @(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        we |-> !$isunknown(w_data)
    ) else $error("reg_file: unknown data written to r%0d", w_idx);

endmodule

`default_nettype wire

// ==== rtl/load_decoder.sv ====
/* Opcode decode for the four supported loads into load control */

`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module load_decoder (
    input  wire logic [5:0]          opcode,   // Instruction bits 31:26
    output mips_pkg::load_ctrl_t     ctrl
);
    import mips_pkg::*;

    // Only I format loads write rt
    // R type, immediate ALU ops, branches and stores fall to default
    always_comb begin
        ctrl.reg_we = 1'b0;         // No-op unless a load matches
        ctrl.kind   = ld_word;      // Don't-care when reg_we low

        case (opcode)
            `MIPS_OP_LBU: begin
                ctrl.reg_we = 1'b1;
                ctrl.kind   = ld_byte;      // rt = zext(mem[7:0])
            end
            `MIPS_OP_LHU: begin
                ctrl.reg_we = 1'b1;
                ctrl.kind   = ld_half;      // rt = zext(mem[15:0])
            end
            `MIPS_OP_LUI: begin
                // No memory access, imm shifted up
                ctrl.reg_we = 1'b1;
                ctrl.kind   = ld_upper;
            end
            `MIPS_OP_LW: begin
                ctrl.reg_we = 1'b1;
                ctrl.kind   = ld_word;      // rt = mem
            end
            default: begin
                // Unsupported opcode, PC still advances
                ctrl.reg_we = 1'b0;
                ctrl.kind   = ld_word;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/load_unit.sv ====
/* Effective address adder and load result formatting for byte, half,
   word and upper immediate */

`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module load_unit (
    input  wire mips_pkg::data_t     base,      // rs value
    input  wire logic [15:0]         imm,       // Instruction offset
    input  wire mips_pkg::load_kind_t kind,
    input  wire mips_pkg::data_t     mem_word,  // DM read at ea_idx
    output mips_pkg::mem_idx_t       ea_idx,
    output mips_pkg::data_t          result
);
    import mips_pkg::*;

    localparam int HALF_W = `MIPS_DATA_W / 2;

    data_t imm_sext;    // Signed offset
    data_t ea;          // Full effective address

    // Single adder, base + sign-extended offset
    assign imm_sext = {{(`MIPS_DATA_W-16){imm[15]}}, imm};
    assign ea       = base + imm_sext;

    // Word addressed memory, low bits pick the word
    assign ea_idx = ea[`MIPS_IDX_W-1:0];

    // Result formatter, goes straight to rt
    always_comb begin
        case (kind)
            ld_byte: begin
                result = {{(`MIPS_DATA_W-8){1'b0}}, mem_word[7:0]};
            end
            ld_half: begin
                result = {{HALF_W{1'b0}}, mem_word[HALF_W-1:0]};
            end
            ld_upper: begin
                // LUI, memory word ignored
                result = {imm, {HALF_W{1'b0}}};
            end
            default: begin
                result = mem_word;  // LW
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mips_load_core.sv ====
/* Single-cycle load-only core: program counter, debug back door steering,
   memories, register file, decoder and load datapath */

`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_load_core (
    input  wire logic                 mem_debug_clk_gate,
    input  wire logic                 HW_RSTn,
    input  wire mips_pkg::data_t      din,          // Debug write data
    output mips_pkg::data_t           dout,         // Debug read data
    input  wire logic [31:0]          addr,         // Debug word index
    input  wire mips_pkg::debug_sel_t debug_func,
    input  wire logic                 debug_we,
    input  wire logic                 mem_debug     // High holds the core
);
    import mips_pkg::*;

    logic [`MIPS_ADDR_W-1:0] pc;
    instr_t     instr;          // Fetched at pc
    load_ctrl_t ctrl;
    data_t      ra_data, rb_data;
    data_t      ld_result;
    mem_idx_t   ld_ea_idx;
    reg_idx_t   dbg_reg_idx;
    mem_idx_t   dbg_mem_idx;
    reg_idx_t   rf_rb_idx, rf_w_idx;
    data_t      rf_w_data;
    logic       rf_we;

    ram_port_if #(.word_t(instr_t)) im_port ();
    ram_port_if #(.word_t(data_t))  dm_port ();

    // Program counter, one word per edge, frozen in debug
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc <= `MIPS_RESET_PC;
        end else if (!mem_debug) begin
            pc <= pc + 1'b1;
        end
    end

    assign dbg_reg_idx = addr[4:0];
    assign dbg_mem_idx = addr[`MIPS_IDX_W-1:0];

    // Instruction memory, fetch or back door
    assign im_port.idx   = mem_debug ? dbg_mem_idx : pc[`MIPS_IDX_W-1:0];
    assign im_port.wdata = instr_t'(din);
    assign im_port.we    = mem_debug && (debug_func == dbg_im) && debug_we;
    assign instr         = im_port.rdata;

    sync_ram #(.word_t(instr_t)) im_ram (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .port               (im_port)
    );

    load_decoder u_decoder (
        .opcode (instr.opcode),
        .ctrl   (ctrl)
    );

    // Register file steering
    // Port b doubles as the debug read port
    assign rf_rb_idx = mem_debug ? dbg_reg_idx : instr.rt;
    assign rf_w_idx  = mem_debug ? dbg_reg_idx : instr.rt;
    assign rf_w_data = mem_debug ? din : ld_result;
    assign rf_we     = mem_debug ? ((debug_func == dbg_mr) && debug_we) : ctrl.reg_we;

    reg_file u_reg_file (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .ra_idx             (instr.rs),
        .rb_idx             (rf_rb_idx),
        .w_idx              (rf_w_idx),
        .w_data             (rf_w_data),
        .we                 (rf_we),
        .ra_data            (ra_data),
        .rb_data            (rb_data)
    );

    load_unit u_load_unit (
        .base     (ra_data),
        .imm      (instr.imm),
        .kind     (ctrl.kind),
        .mem_word (dm_port.rdata),
        .ea_idx   (ld_ea_idx),
        .result   (ld_result)
    );

    // Data memory, loads only, written from the back door
    assign dm_port.idx   = mem_debug ? dbg_mem_idx : ld_ea_idx;
    assign dm_port.wdata = din;
    assign dm_port.we    = mem_debug && (debug_func == dbg_dm) && debug_we;

    sync_ram #(.word_t(data_t)) dm_ram (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .port               (dm_port)
    );

    // Debug read mux
    always_comb begin
        case (debug_func)
            dbg_im:  dout = data_t'(im_port.rdata);
            dbg_dm:  dout = dm_port.rdata;
            dbg_mr:  dout = rb_data;          // Register at addr[4:0]
            default: dout = '0;               // No target
        endcase
    end

endmodule

`default_nettype wire

// ==== dv/tb_mips_load_core.sv ====
/* Directed testbench for the load-only core: clock, reset, debug access,
   compare tasks and the load tests */

`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module tb_mips_load_core;
    import mips_pkg::*;

    localparam int  CLK_PERIOD  = 8;
    localparam time WATCHDOG_NS = 200_000;     // Whole run limit

    logic       mem_debug_clk_gate;
    logic       HW_RSTn;
    data_t      din;
    data_t      dout;
    logic [31:0] addr;
    debug_sel_t debug_func;
    logic       debug_we;
    logic       mem_debug;

    integer seed;                   // $random state
    string  cur_test;
    int     test_errs;
    int     tests_passed;
    int     tests_failed;

    mips_load_core uut (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .din                (din),
        .dout               (dout),
        .addr               (addr),
        .debug_func         (debug_func),
        .debug_we           (debug_we),
        .mem_debug          (mem_debug)
    );

    always #(CLK_PERIOD / 2) mem_debug_clk_gate = ~mem_debug_clk_gate;

    // Stalled clock or runaway test
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation ran past its time limit");
        $display("Done: errors found");
        $finish;
    end

    task automatic stall_abort(input string what);
        $display("Timeout: %s during test %s", what, cur_test);
        $display("Done: errors found");
        $finish;
    endtask

    // Count clock edges, rising or falling, with a time guard
    task automatic wait_clk(input int n, input bit rising);
        int  seen;
        time t0;
        time limit;
        seen  = 0;
        t0    = $time;
        limit = time'(n + 1) * CLK_PERIOD;
        while (seen < n) begin
            if (rising) @(posedge mem_debug_clk_gate);
            else        @(negedge mem_debug_clk_gate);
            seen++;
            if (($time - t0) > limit) stall_abort("clock edges late");
        end
    endtask

    task automatic apply_reset();
        wait_clk(1, 0);
        HW_RSTn    = 1'b0;
        mem_debug  = 1'b1;          // Core held
        debug_we   = 1'b0;
        debug_func = dbg_none;
        addr       = '0;
        din        = '0;
        wait_clk(10, 1);
        wait_clk(1, 0);
        HW_RSTn = 1'b1;
    endtask

    // Single-edge write through the back door
    task automatic dbg_write(input debug_sel_t target, input logic [31:0] index,
                             input data_t value);
        wait_clk(1, 0);
        mem_debug  = 1'b1;
        debug_func = target;
        addr       = index;
        din        = value;
        debug_we   = 1'b1;
        wait_clk(1, 1);
        wait_clk(1, 0);
        debug_we = 1'b0;
    endtask

    // dout settles combinationally, sampled at the next rising edge
    task automatic dbg_read(input debug_sel_t target, input logic [31:0] index,
                            output data_t value);
        wait_clk(1, 0);
        mem_debug  = 1'b1;
        debug_func = target;
        addr       = index;
        debug_we   = 1'b0;
        wait_clk(1, 1);
        value = dout;
    endtask

    // Exactly n instructions, one per rising edge
    task automatic run(input int n);
        wait_clk(1, 0);
        debug_we   = 1'b0;
        debug_func = dbg_none;
        mem_debug  = 1'b0;
        wait_clk(n, 1);
        wait_clk(1, 0);
        mem_debug = 1'b1;
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_instr(input string what, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    function automatic instr_t make_instr(input logic [5:0] op, input reg_idx_t rs,
                                          input reg_idx_t rt, input logic [15:0] imm);
        instr_t ins;
        ins.opcode = op;
        ins.rs     = rs;
        ins.rt     = rt;
        ins.imm    = imm;
        return ins;
    endfunction

    function automatic bit is_load_op(input logic [5:0] op);
        return (op == `MIPS_OP_LBU) || (op == `MIPS_OP_LHU) ||
               (op == `MIPS_OP_LUI) || (op == `MIPS_OP_LW);
    endfunction

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("%s: passed", cur_test);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    task automatic test_reset_state();
        int    idx_list [4] = '{0, 1, 13, 31};
        data_t val;
        start_test("reset_state");
        apply_reset();
        // Nonzero contents for the second reset to clear
        foreach (idx_list[i]) begin
            dbg_write(dbg_im, idx_list[i], data_t'($random(seed)) | 32'h1);
            dbg_write(dbg_dm, idx_list[i], data_t'($random(seed)) | 32'h1);
            dbg_write(dbg_mr, idx_list[i], data_t'($random(seed)) | 32'h1);
        end
        dbg_read(dbg_none, 32'd13, val);        // No target, storage not empty
        check_data("none target", '0, val);
        apply_reset();
        foreach (idx_list[i]) begin
            dbg_read(dbg_im, idx_list[i], val);
            check_instr($sformatf("im[%0d]", idx_list[i]), '0, instr_t'(val));
            dbg_read(dbg_dm, idx_list[i], val);
            check_data($sformatf("dm[%0d]", idx_list[i]), '0, val);
            dbg_read(dbg_mr, idx_list[i], val);
            check_data($sformatf("r%0d", idx_list[i]), '0, val);
        end
        finish_test();
    endtask

    task automatic test_round_trip();
        data_t im_exp [32];
        data_t dm_exp [32];
        data_t mr_exp [32];
        data_t val;
        start_test("debug_round_trip");
        apply_reset();
        mr_exp[0] = '0;                         // r0 hard-wired
        for (int i = 0; i < 32; i++) begin
            im_exp[i] = $random(seed);
            dm_exp[i] = $random(seed);
            dbg_write(dbg_im, i, im_exp[i]);
            dbg_write(dbg_dm, i, dm_exp[i]);
            if (i != 0) begin
                mr_exp[i] = $random(seed);
                dbg_write(dbg_mr, i, mr_exp[i]);
            end
        end
        dbg_write(dbg_mr, 32'd0, 32'hdead_beef);  // Must be dropped
        for (int i = 0; i < 32; i++) begin
            dbg_read(dbg_im, i, val);
            check_instr($sformatf("im[%0d]", i), instr_t'(im_exp[i]), instr_t'(val));
            dbg_read(dbg_dm, i, val);
            check_data($sformatf("dm[%0d]", i), dm_exp[i], val);
            dbg_read(dbg_mr, i, val);
            check_data($sformatf("r%0d", i), mr_exp[i], val);
        end
        finish_test();
    endtask

    task automatic test_lw_lui();
        data_t       base;
        data_t       word;
        data_t       got;
        mem_idx_t    k;
        logic [15:0] imm_lw;
        logic [15:0] imm_lui;
        start_test("lw_lui");
        apply_reset();
        k       = mem_idx_t'($random(seed));
        base    = data_t'($random(seed)) & 32'h0000_03ff;
        imm_lw  = 16'(32'(k) - base);           // Low bits of base+imm land on k
        imm_lui = 16'($random(seed));
        word    = $random(seed);
        dbg_write(dbg_dm, 32'(k), word);
        dbg_write(dbg_mr, 32'd1, base);
        dbg_write(dbg_im, 32'd0, data_t'(make_instr(`MIPS_OP_LW, 5'd1, 5'd2, imm_lw)));
        dbg_write(dbg_im, 32'd1, data_t'(make_instr(`MIPS_OP_LUI, 5'd0, 5'd3, imm_lui)));
        run(2);
        dbg_read(dbg_mr, 32'd2, got);
        check_data("r2 after LW", word, got);
        dbg_read(dbg_mr, 32'd3, got);
        check_data("r3 after LUI", {imm_lui, 16'h0000}, got);
        finish_test();
    endtask

    task automatic test_lbu_lhu();
        data_t       base;
        data_t       w_byte;
        data_t       w_half;
        data_t       got;
        mem_idx_t    k1;
        mem_idx_t    k2;
        logic [15:0] imm1;
        logic [15:0] imm2;
        start_test("lbu_lhu");
        apply_reset();
        k1     = mem_idx_t'($random(seed));
        k2     = k1 + 5'd3;
        base   = 32'd40 + (data_t'($random(seed)) & 32'h0000_00ff);
        imm1   = 16'(32'(k1) - base);           // Always negative, base > 31
        imm2   = 16'(32'(k2) - base);
        w_byte = data_t'($random(seed)) | 32'h8000_8080;   // High bits set
        w_half = data_t'($random(seed)) | 32'h8000_8000;
        dbg_write(dbg_dm, 32'(k1), w_byte);
        dbg_write(dbg_dm, 32'(k2), w_half);
        dbg_write(dbg_mr, 32'd1, base);
        dbg_write(dbg_im, 32'd0, data_t'(make_instr(`MIPS_OP_LBU, 5'd1, 5'd4, imm1)));
        dbg_write(dbg_im, 32'd1, data_t'(make_instr(`MIPS_OP_LHU, 5'd1, 5'd6, imm2)));
        run(2);
        dbg_read(dbg_mr, 32'd4, got);
        check_data("r4 after LBU", {24'h00_0000, w_byte[7:0]}, got);
        dbg_read(dbg_mr, 32'd6, got);
        check_data("r6 after LHU", {16'h0000, w_half[15:0]}, got);
        finish_test();
    endtask

    task automatic test_unsupported_ops();
        data_t       regs_exp [32];
        data_t       dm_word  [32];
        data_t       got;
        data_t       ea;
        instr_t      ins;
        logic [15:0] imm;
        start_test("unsupported_ops");
        apply_reset();
        regs_exp[0] = '0;
        for (int i = 0; i < 32; i++) begin
            dm_word[i] = $random(seed);
            dbg_write(dbg_dm, i, dm_word[i]);
            if (i != 0) begin
                regs_exp[i] = $random(seed);
                dbg_write(dbg_mr, i, regs_exp[i]);
            end
        end
        // Six no-ops with random fields
        for (int i = 0; i < 6; i++) begin
            ins = instr_t'($random(seed));
            if (is_load_op(ins.opcode)) ins.opcode = 6'b000000;
            dbg_write(dbg_im, i, data_t'(ins));
        end
        imm = 16'($random(seed));
        ea  = regs_exp[7] + {{16{imm[15]}}, imm};
        regs_exp[5] = dm_word[ea[4:0]];         // Only change expected
        dbg_write(dbg_im, 32'd6, data_t'(make_instr(`MIPS_OP_LW, 5'd7, 5'd5, imm)));
        run(7);
        for (int i = 0; i < 32; i++) begin
            dbg_read(dbg_mr, i, got);
            check_data($sformatf("r%0d", i), regs_exp[i], got);
        end
        finish_test();
    endtask

    initial begin
        seed               = 32'ha50ffacc;
        mem_debug_clk_gate = 1'b0;
        HW_RSTn            = 1'b0;
        din                = '0;
        addr               = '0;
        debug_func         = dbg_none;
        debug_we           = 1'b0;
        mem_debug          = 1'b1;
        tests_passed       = 0;
        tests_failed       = 0;
        cur_test           = "init";

        test_reset_state();
        test_round_trip();
        test_lw_lui();
        test_lbu_lhu();
        test_unsupported_ops();

        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
rtl/mips_pkg.sv
rtl/ram_port_if.sv
rtl/sync_ram.sv
rtl/reg_file.sv
rtl/load_decoder.sv
rtl/load_unit.sv
rtl/mips_load_core.sv
dv/tb_mips_load_core.sv

// ==== Makefile ====
TOP := tb_mips_load_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
